//--- src/uart_macros.svh
// Frame shape and bus map are fixed at build time; changing STOP_BITS or DATA_BITS needs a rebuild
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Frame shape
`define DATA_BITS 8
`define STOP_BITS 2

// Baud timing, ticks per bit and the tick used for sampling
`define OVERSAMPLE 16
`define SAMPLE_POINT 8
`define DIV_WIDTH 16
`define DIV_RESET 7

// AXI4-Lite register map
`define ADDR_WIDTH 4
`define REG_TXDATA 'h0
`define REG_RXDATA 'h4
`define REG_STATUS 'h8
`define REG_DIVISOR 'hC

// STATUS bit positions
`define ST_TXBUSY 0
`define ST_RXVALID 1
`define ST_OVERRUN 2
`define ST_BREAK 3
`define ST_PARITY 4
`define ST_FRAMING 5

`endif

//--- src/uartPkg.sv
// Enums only; all widths and register offsets come from uart_macros.svh
`include "uart_macros.svh"

package uartPkg;

	// Receiver states, in the order a frame walks through them
	typedef enum logic [2:0] {
		Ready,
		StartBit,
		DataBits,
		ParityBit,
		StopBits,
		RxDone
	} rxState;

	// Transmitter states
	typedef enum logic [2:0] {
		TxIdle,
		TxStart,
		TxData,
		TxParity,
		TxStop
	} txState;

	// One machine per AXI channel pair
	typedef enum logic {
		BusIdle,
		BusResp
	} busState;

	// Register offsets used as opcodes for decoding
	typedef enum logic [`ADDR_WIDTH-1:0] {
		RegTxData = `REG_TXDATA,
		RegRxData = `REG_RXDATA,
		RegStatus = `REG_STATUS,
		RegDivisor = `REG_DIVISOR
	} regAddr;

endpackage

//--- src/baudTickGen.sv
// Tick period is Divisor+1 clocks; any change of Divisor restarts the count from zero
`include "uart_macros.svh"

module baudTickGen (
	input  logic                  Clk,
	input  logic                  Rst,
	input  logic [`DIV_WIDTH-1:0] Divisor,
	output logic                  Tick
);

	logic [`DIV_WIDTH-1:0] count;
	logic [`DIV_WIDTH-1:0] lastDivisor;

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			count <= '0;
			lastDivisor <= `DIV_WIDTH'(`DIV_RESET);
			Tick <= 1'b0;
		end
		else
		begin
			lastDivisor <= Divisor;
			// New rate starts from a clean phase
			if (Divisor != lastDivisor)
			begin
				count <= '0;
				Tick <= 1'b0;
			end
			else if (count >= Divisor)
			begin
				count <= '0;
				Tick <= 1'b1;
			end
			else
			begin
				count <= count + 1'b1;
				Tick <= 1'b0;
			end
		end
	end

endmodule

//--- src/uartRx.sv
// Rxd must already be synchronous to Clk; frames are DATA_BITS MSB first, even parity, STOP_BITS stops
`include "uart_macros.svh"

module uartRx (
	input  logic                  Clk,
	input  logic                  Rst,
	input  logic                  Tick,
	input  logic                  Rxd,
	output logic                  Rts,
	output logic                  RxValid,
	output logic [`DATA_BITS-1:0] RxByte,
	output logic                  BreakErr,
	output logic                  ParityErr,
	output logic                  FramingErr
);

	localparam int TickW = $clog2(`OVERSAMPLE);
	localparam int BitW = $clog2(`DATA_BITS);
	localparam int StopW = (`STOP_BITS > 1) ? $clog2(`STOP_BITS) : 1;
	localparam logic [TickW-1:0] LastTick = TickW'(`OVERSAMPLE - 1);
	localparam logic [TickW-1:0] StartTick = TickW'(`SAMPLE_POINT - 1);
	localparam logic [BitW-1:0] LastBit = BitW'(`DATA_BITS - 1);
	localparam logic [StopW-1:0] LastStop = StopW'(`STOP_BITS - 1);

	uartPkg::rxState state;
	uartPkg::rxState nextState;
	logic [TickW-1:0] tickCnt;
	logic [BitW-1:0] bitCnt;
	logic [StopW-1:0] stopCnt;
	logic [`DATA_BITS-1:0] dataReg;
	logic parityReg;
	logic [`STOP_BITS-1:0] stopReg;
	logic sampleNow;
	logic stopBad;
	logic parityBad;
	logic frameOk;

	// Start bit is checked mid-bit, every later bit one full bit after the previous sample
	assign sampleNow = Tick && ((state == uartPkg::StartBit) ? (tickCnt == StartTick)
		: (tickCnt == LastTick));

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			state <= uartPkg::Ready;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			uartPkg::Ready:
				if (Tick && !Rxd)
					nextState = uartPkg::StartBit;
			uartPkg::StartBit:
				// A high line at the sample point was only a glitch
				if (sampleNow)
					nextState = Rxd ? uartPkg::Ready : uartPkg::DataBits;
			uartPkg::DataBits:
				if (sampleNow && bitCnt == LastBit)
					nextState = uartPkg::ParityBit;
			uartPkg::ParityBit:
				if (sampleNow)
					nextState = uartPkg::StopBits;
			uartPkg::StopBits:
				if (sampleNow && stopCnt == LastStop)
					nextState = uartPkg::RxDone;
			default:
				nextState = uartPkg::Ready;
		endcase
	end

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			tickCnt <= '0;
			bitCnt <= '0;
			stopCnt <= '0;
		end
		else if (state == uartPkg::Ready || state == uartPkg::RxDone)
		begin
			tickCnt <= '0;
			bitCnt <= '0;
			stopCnt <= '0;
		end
		else if (Tick)
		begin
			if (sampleNow)
			begin
				tickCnt <= '0;
				if (state == uartPkg::DataBits)
					bitCnt <= bitCnt + 1'b1;
				if (state == uartPkg::StopBits)
					stopCnt <= stopCnt + 1'b1;
			end
			else
				tickCnt <= tickCnt + 1'b1;
		end
	end

	// Every bit of these is rewritten each frame before RxDone
	always_ff @(posedge Clk)
	begin
		if (sampleNow)
		begin
			case (state)
				uartPkg::DataBits:
					dataReg <= {dataReg[`DATA_BITS-2:0], Rxd};
				uartPkg::ParityBit:
					parityReg <= Rxd;
				uartPkg::StopBits:
					stopReg[stopCnt] <= Rxd;
				default:
					;
			endcase
		end
	end

	assign stopBad = ~&stopReg;
	assign parityBad = (^dataReg) != parityReg;
	assign frameOk = (state == uartPkg::RxDone) && !parityBad && !stopBad;

	assign ParityErr = (state == uartPkg::RxDone) && parityBad;
	assign FramingErr = (state == uartPkg::RxDone) && stopBad;
	// Break also counts as a framing error
	assign BreakErr = (state == uartPkg::RxDone) && (dataReg == '0) && stopBad;
	assign RxValid = frameOk;
	assign RxByte = frameOk ? dataReg : '0;
	assign Rts = (state == uartPkg::Ready);

	aValidClean: assert property (@(posedge Clk) disable iff (Rst)
		RxValid |-> !(BreakErr || ParityErr || FramingErr));
	aDoneRts: assert property (@(posedge Clk) disable iff (Rst)
		state == uartPkg::RxDone |=> Rts);
	aKnown: assert property (@(posedge Clk) disable iff (Rst)
		!$isunknown({Rts, RxValid, RxByte, BreakErr, ParityErr, FramingErr}));

endmodule

//--- src/uartTx.sv
// TxStart is honoured only while idle; the frame begins on the first tick after it
`include "uart_macros.svh"

module uartTx (
	input  logic                  Clk,
	input  logic                  Rst,
	input  logic                  Tick,
	input  logic                  TxStart,
	input  logic [`DATA_BITS-1:0] TxByte,
	output logic                  Txd,
	output logic                  TxBusy
);

	localparam int TickW = $clog2(`OVERSAMPLE);
	localparam int BitW = $clog2(`DATA_BITS);
	localparam int StopW = (`STOP_BITS > 1) ? $clog2(`STOP_BITS) : 1;
	localparam logic [TickW-1:0] LastTick = TickW'(`OVERSAMPLE - 1);
	localparam logic [BitW-1:0] LastBit = BitW'(`DATA_BITS - 1);
	localparam logic [StopW-1:0] LastStop = StopW'(`STOP_BITS - 1);

	uartPkg::txState state;
	logic pending;
	logic [TickW-1:0] tickCnt;
	logic [BitW-1:0] bitCnt;
	logic [StopW-1:0] stopCnt;
	logic [`DATA_BITS-1:0] shiftReg;
	logic parityBit;

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state <= uartPkg::TxIdle;
			pending <= 1'b0;
			tickCnt <= '0;
			bitCnt <= '0;
			stopCnt <= '0;
		end
		else if (state == uartPkg::TxIdle)
		begin
			tickCnt <= '0;
			bitCnt <= '0;
			stopCnt <= '0;
			if (TxStart)
				pending <= 1'b1;
			else if (pending && Tick)
			begin
				pending <= 1'b0;
				state <= uartPkg::TxStart;
			end
		end
		else if (Tick)
		begin
			if (tickCnt != LastTick)
				tickCnt <= tickCnt + 1'b1;
			else
			begin
				// Bit boundary
				tickCnt <= '0;
				case (state)
					uartPkg::TxStart:
						state <= uartPkg::TxData;
					uartPkg::TxData:
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == LastBit)
							state <= uartPkg::TxParity;
					end
					uartPkg::TxParity:
						state <= uartPkg::TxStop;
					default:
					begin
						stopCnt <= stopCnt + 1'b1;
						if (stopCnt == LastStop)
							state <= uartPkg::TxIdle;
					end
				endcase
			end
		end
	end

	always_ff @(posedge Clk)
	begin
		if (state == uartPkg::TxIdle && TxStart)
		begin
			shiftReg <= TxByte;
			parityBit <= ^TxByte;
		end
		else if (state == uartPkg::TxData && Tick && tickCnt == LastTick)
			shiftReg <= {shiftReg[`DATA_BITS-2:0], 1'b0};
	end

	always_comb
	begin
		case (state)
			uartPkg::TxStart:
				Txd = 1'b0;
			uartPkg::TxData:
				Txd = shiftReg[`DATA_BITS-1];
			uartPkg::TxParity:
				Txd = parityBit;
			default:
				Txd = 1'b1;
		endcase
	end

	assign TxBusy = pending || (state != uartPkg::TxIdle);

	aIdleHigh: assert property (@(posedge Clk) disable iff (Rst)
		state == uartPkg::TxIdle |-> Txd);

endmodule

//--- src/uartAxiRegs.sv
// Single outstanding transfer per channel; only WStrb lanes covering a register are honoured
`include "uart_macros.svh"

module uartAxiRegs (
	input  logic                   Clk,
	input  logic                   Rst,
	input  logic [`ADDR_WIDTH-1:0] AwAddr,
	input  logic                   AwValid,
	output logic                   AwReady,
	input  logic [31:0]            WData,
	input  logic [3:0]             WStrb,
	input  logic                   WValid,
	output logic                   WReady,
	output logic [1:0]             BResp,
	output logic                   BValid,
	input  logic                   BReady,
	input  logic [`ADDR_WIDTH-1:0] ArAddr,
	input  logic                   ArValid,
	output logic                   ArReady,
	output logic [31:0]            RData,
	output logic [1:0]             RResp,
	output logic                   RValid,
	input  logic                   RReady,
	input  logic                   TxBusy,
	output logic                   TxStart,
	output logic [`DATA_BITS-1:0]  TxByte,
	input  logic                   RxValid,
	input  logic [`DATA_BITS-1:0]  RxByte,
	input  logic                   BreakErr,
	input  logic                   ParityErr,
	input  logic                   FramingErr,
	output logic [`DIV_WIDTH-1:0]  Divisor
);

	localparam logic [1:0] RespOkay = 2'b00;
	localparam logic [1:0] RespSlvErr = 2'b10;

	uartPkg::busState wrState;
	uartPkg::busState rdState;
	uartPkg::regAddr wrAddr;
	uartPkg::regAddr rdAddr;
	logic wrAccept;
	logic rdAccept;
	logic wrErr;
	logic rdErr;
	logic [31:0] rdWord;
	logic clrStatus;
	logic rxClear;
	logic [`DATA_BITS-1:0] rxHold;
	logic rxFull;
	logic overrun;
	logic breakFlag;
	logic parityFlag;
	logic framingFlag;

	assign wrAddr = uartPkg::regAddr'(AwAddr);
	assign rdAddr = uartPkg::regAddr'(ArAddr);

	// Address and data are taken together
	assign wrAccept = AwValid && WValid && (wrState == uartPkg::BusIdle);
	assign AwReady = wrAccept;
	assign WReady = wrAccept;
	assign ArReady = (rdState == uartPkg::BusIdle);
	assign rdAccept = ArValid && ArReady;
	assign BValid = (wrState == uartPkg::BusResp);
	assign RValid = (rdState == uartPkg::BusResp);

	assign clrStatus = wrAccept && (wrAddr == uartPkg::RegStatus) && WStrb[0];
	assign rxClear = rdAccept && (rdAddr == uartPkg::RegRxData);

	always_comb
	begin
		case (wrAddr)
			// TxStart covers the cycle before the transmitter reports busy
			uartPkg::RegTxData:
				wrErr = TxBusy || TxStart;
			uartPkg::RegRxData, uartPkg::RegStatus, uartPkg::RegDivisor:
				wrErr = 1'b0;
			default:
				wrErr = 1'b1;
		endcase
	end

	always_comb
	begin
		rdWord = '0;
		rdErr = 1'b0;
		case (rdAddr)
			uartPkg::RegTxData:
				rdWord = '0;
			uartPkg::RegRxData:
				rdWord[`DATA_BITS-1:0] = rxHold;
			uartPkg::RegStatus:
			begin
				rdWord[`ST_TXBUSY] = TxBusy;
				rdWord[`ST_RXVALID] = rxFull;
				rdWord[`ST_OVERRUN] = overrun;
				rdWord[`ST_BREAK] = breakFlag;
				rdWord[`ST_PARITY] = parityFlag;
				rdWord[`ST_FRAMING] = framingFlag;
			end
			uartPkg::RegDivisor:
				rdWord[`DIV_WIDTH-1:0] = Divisor;
			default:
				rdErr = 1'b1;
		endcase
	end

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			wrState <= uartPkg::BusIdle;
			rdState <= uartPkg::BusIdle;
			TxStart <= 1'b0;
			Divisor <= `DIV_WIDTH'(`DIV_RESET);
			rxHold <= '0;
			rxFull <= 1'b0;
			overrun <= 1'b0;
			breakFlag <= 1'b0;
			parityFlag <= 1'b0;
			framingFlag <= 1'b0;
		end
		else
		begin
			if (wrState == uartPkg::BusIdle)
				wrState <= wrAccept ? uartPkg::BusResp : uartPkg::BusIdle;
			else if (BReady)
				wrState <= uartPkg::BusIdle;
			if (rdState == uartPkg::BusIdle)
				rdState <= rdAccept ? uartPkg::BusResp : uartPkg::BusIdle;
			else if (RReady)
				rdState <= uartPkg::BusIdle;

			TxStart <= wrAccept && (wrAddr == uartPkg::RegTxData) && !wrErr && WStrb[0];
			if (wrAccept && wrAddr == uartPkg::RegDivisor)
				for (int b = 0; b < `DIV_WIDTH / 8; b++)
					if (WStrb[b])
						Divisor[b*8 +: 8] <= WData[b*8 +: 8];

			// Holding byte keeps the first arrival on overrun
			if (RxValid && rxFull && !rxClear)
				overrun <= 1'b1;
			else if (clrStatus && WData[`ST_OVERRUN])
				overrun <= 1'b0;
			if (RxValid && (!rxFull || rxClear))
			begin
				rxHold <= RxByte;
				rxFull <= 1'b1;
			end
			else if (rxClear)
				rxFull <= 1'b0;

			// Sticky flags, new errors win over a clear in the same cycle
			if (BreakErr)
				breakFlag <= 1'b1;
			else if (clrStatus && WData[`ST_BREAK])
				breakFlag <= 1'b0;
			if (ParityErr)
				parityFlag <= 1'b1;
			else if (clrStatus && WData[`ST_PARITY])
				parityFlag <= 1'b0;
			if (FramingErr)
				framingFlag <= 1'b1;
			else if (clrStatus && WData[`ST_FRAMING])
				framingFlag <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (wrAccept)
		begin
			BResp <= wrErr ? RespSlvErr : RespOkay;
			if (wrAddr == uartPkg::RegTxData && !wrErr)
				TxByte <= WData[`DATA_BITS-1:0];
		end
		if (rdAccept)
		begin
			RData <= rdWord;
			RResp <= rdErr ? RespSlvErr : RespOkay;
		end
	end

	aBHold: assert property (@(posedge Clk) disable iff (Rst)
		BValid && !BReady |=> BValid && $stable(BResp));
	aRHold: assert property (@(posedge Clk) disable iff (Rst)
		RValid && !RReady |=> RValid && $stable(RData) && $stable(RResp));

endmodule

//--- src/uartTop.sv
// Rxd is used without a synchronizer, so it must come from the Clk domain
`include "uart_macros.svh"

module uartTop (
	input  logic                   Clk,
	input  logic                   Rst,
	input  logic [`ADDR_WIDTH-1:0] AwAddr,
	input  logic                   AwValid,
	output logic                   AwReady,
	input  logic [31:0]            WData,
	input  logic [3:0]             WStrb,
	input  logic                   WValid,
	output logic                   WReady,
	output logic [1:0]             BResp,
	output logic                   BValid,
	input  logic                   BReady,
	input  logic [`ADDR_WIDTH-1:0] ArAddr,
	input  logic                   ArValid,
	output logic                   ArReady,
	output logic [31:0]            RData,
	output logic [1:0]             RResp,
	output logic                   RValid,
	input  logic                   RReady,
	input  logic                   Rxd,
	output logic                   Txd,
	output logic                   Rts
);

	logic tick;
	logic [`DIV_WIDTH-1:0] divisor;
	logic txStart;
	logic [`DATA_BITS-1:0] txByte;
	logic txBusy;
	logic rxValid;
	logic [`DATA_BITS-1:0] rxByte;
	logic breakErr;
	logic parityErr;
	logic framingErr;

	uartAxiRegs u_axiRegs (
		.Clk(Clk), .Rst(Rst),
		.AwAddr(AwAddr), .AwValid(AwValid), .AwReady(AwReady),
		.WData(WData), .WStrb(WStrb), .WValid(WValid), .WReady(WReady),
		.BResp(BResp), .BValid(BValid), .BReady(BReady),
		.ArAddr(ArAddr), .ArValid(ArValid), .ArReady(ArReady),
		.RData(RData), .RResp(RResp), .RValid(RValid), .RReady(RReady),
		.TxBusy(txBusy), .TxStart(txStart), .TxByte(txByte),
		.RxValid(rxValid), .RxByte(rxByte),
		.BreakErr(breakErr), .ParityErr(parityErr), .FramingErr(framingErr),
		.Divisor(divisor)
	);

	// One tick source paces both directions
	baudTickGen u_tickGen (
		.Clk(Clk), .Rst(Rst), .Divisor(divisor), .Tick(tick)
	);

	uartRx u_rx (
		.Clk(Clk), .Rst(Rst), .Tick(tick), .Rxd(Rxd), .Rts(Rts),
		.RxValid(rxValid), .RxByte(rxByte),
		.BreakErr(breakErr), .ParityErr(parityErr), .FramingErr(framingErr)
	);

	uartTx u_tx (
		.Clk(Clk), .Rst(Rst), .Tick(tick), .TxStart(txStart), .TxByte(txByte),
		.Txd(Txd), .TxBusy(txBusy)
	);

endmodule

//--- bench/uartChecker.sv
// Assumes full-word bus writes, a divisor that is constant during a frame and idle lines at test end
`include "uart_macros.svh"

module uartChecker (
	input  logic                   Clk,
	input  logic                   Rst,
	input  logic [`ADDR_WIDTH-1:0] AwAddr,
	input  logic                   AwValid,
	input  logic                   AwReady,
	input  logic [31:0]            WData,
	input  logic                   WReady,
	input  logic [1:0]             BResp,
	input  logic                   BValid,
	input  logic                   BReady,
	input  logic [`ADDR_WIDTH-1:0] ArAddr,
	input  logic                   ArValid,
	input  logic                   ArReady,
	input  logic [31:0]            RData,
	input  logic [1:0]             RResp,
	input  logic                   RValid,
	input  logic                   RReady,
	input  logic                   Rxd,
	input  logic                   Txd,
	input  logic                   Rts,
	input  logic [8*20-1:0]        TestName,
	input  logic                   TestDone,
	input  logic                   Finish,
	output int                     ErrCount
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FrameLen = 1 + `DATA_BITS + 1 + `STOP_BITS;
	localparam logic [1:0] Okay = 2'b00;
	localparam logic [1:0] SlvErr = 2'b10;

	// Register model
	logic [`DIV_WIDTH-1:0] div;
	logic [`DATA_BITS-1:0] rxHold;
	logic rxFull;
	logic ovr;
	logic brkF;
	logic parF;
	logic frmF;
	logic txPend;
	int txLeft;
	// Bytes written to TXDATA, expected back on the looped line
	logic [`DATA_BITS-1:0] txQ[$];
	logic [`DATA_BITS-1:0] txByte;
	logic [FrameLen-2:0] expFrame;
	// Serial line decoder
	logic rxActive;
	logic lastRxd;
	int rxClocks;
	int bitIdx;
	int bitClk;
	logic [`DATA_BITS-1:0] dataSh;
	logic parBit;
	logic [`STOP_BITS-1:0] stopSh;
	// Outstanding responses with {resp, data} for reads
	logic [1:0] bQ[$];
	logic [33:0] rQ[$];
	logic busyNow;
	logic [1:0] expResp;
	logic [31:0] expData;
	logic [33:0] expRead;
	logic [`DATA_BITS+3:0] res;
	int testErrs;
	int testsRun;
	int testsFailed;

	// Frame rules giving {valid, break, parity, framing, byte}
	function automatic logic [`DATA_BITS+3:0] predictFrame(input logic [`DATA_BITS-1:0] data,
		input logic parity, input logic [`STOP_BITS-1:0] stops);
		logic parE;
		logic frmE;
		logic brkE;
		parE = (^data) != parity;
		frmE = !(&stops);
		brkE = (data == '0) && frmE;
		return {!(parE || frmE), brkE, parE, frmE, data};
	endfunction

	function automatic logic [31:0] statusWord(input logic busy);
		logic [31:0] w;
		w = '0;
		w[`ST_TXBUSY] = busy;
		w[`ST_RXVALID] = rxFull;
		w[`ST_OVERRUN] = ovr;
		w[`ST_BREAK] = brkF;
		w[`ST_PARITY] = parF;
		w[`ST_FRAMING] = frmF;
		return w;
	endfunction

	task automatic failNote(input string what);
		$display("Error in test %0s: %0s", TestName, what);
		testErrs++;
		ErrCount++;
	endtask

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("Mismatch in test %0s: %0s expected 0x%0h actual 0x%0h",
			TestName, what, exp, act);
		testErrs++;
		ErrCount++;
	endtask

	always @(posedge Clk)
	begin
		if (Rst)
		begin
			div = `DIV_WIDTH'(`DIV_RESET);
			rxHold = '0;
			{rxFull, ovr, brkF, parF, frmF, txPend} = '0;
			txLeft = 0;
			rxActive = 1'b0;
			lastRxd = 1'b1;
			bQ.delete();
			rQ.delete();
			txQ.delete();
			{ErrCount, testErrs, testsRun, testsFailed} = '0;
		end
		else
		begin
			busyNow = txPend || (txLeft > 0);
			bitClk = `OVERSAMPLE * (int'(div) + 1);
			if (!busyNow && Txd !== 1'b1)
				failNote("Txd left the idle level with no frame to send");
			// Busy lasts one full frame from the falling edge of Txd
			if (txLeft > 0)
				txLeft--;
			else if (txPend && !Txd)
			begin
				txPend = 1'b0;
				txLeft = FrameLen * bitClk - 1;
			end

			if (WReady !== AwReady)
				failNote("WReady did not follow AwReady");

			if (AwValid && AwReady)
			begin
				expResp = Okay;
				case (AwAddr)
					uartPkg::RegTxData:
						if (busyNow)
							expResp = SlvErr;
						else
						begin
							txPend = 1'b1;
							txQ.push_back(WData[`DATA_BITS-1:0]);
						end
					uartPkg::RegRxData:
						;
					uartPkg::RegStatus:
					begin
						ovr = ovr && !WData[`ST_OVERRUN];
						brkF = brkF && !WData[`ST_BREAK];
						parF = parF && !WData[`ST_PARITY];
						frmF = frmF && !WData[`ST_FRAMING];
					end
					uartPkg::RegDivisor:
						div = WData[`DIV_WIDTH-1:0];
					default:
						expResp = SlvErr;
				endcase
				bQ.push_back(expResp);
			end
			if (BValid && BReady)
			begin
				if (bQ.size() == 0)
					failNote("write response with no write accepted");
				else
				begin
					expResp = bQ.pop_front();
					if (BResp !== expResp)
						mismatch("BResp", 32'(expResp), 32'(BResp));
				end
			end

			if (ArValid && ArReady)
			begin
				expData = '0;
				expResp = Okay;
				case (ArAddr)
					uartPkg::RegTxData:
						;
					uartPkg::RegRxData:
					begin
						expData[`DATA_BITS-1:0] = rxHold;
						rxFull = 1'b0;
					end
					uartPkg::RegStatus:
						expData = statusWord(busyNow);
					uartPkg::RegDivisor:
						expData[`DIV_WIDTH-1:0] = div;
					default:
						expResp = SlvErr;
				endcase
				rQ.push_back({expResp, expData});
			end
			if (RValid && RReady)
			begin
				if (rQ.size() == 0)
					failNote("read response with no read accepted");
				else
				begin
					expRead = rQ.pop_front();
					if (RResp !== expRead[33:32])
						mismatch("RResp", 32'(expRead[33:32]), 32'(RResp));
					if (RData !== expRead[31:0])
						mismatch("RData", expRead[31:0], RData);
				end
			end

			// Mid-bit sampling of the receive line
			if (!rxActive)
			begin
				if (lastRxd && !Rxd)
				begin
					rxActive = 1'b1;
					rxClocks = 0;
					bitIdx = 0;
				end
			end
			else
			begin
				rxClocks++;
				if (rxClocks == bitClk * bitIdx + bitClk / 2)
				begin
					if (bitIdx == 0 && Rxd)
						rxActive = 1'b0;
					else if (bitIdx <= `DATA_BITS)
						dataSh = {dataSh[`DATA_BITS-2:0], Rxd};
					else if (bitIdx == `DATA_BITS + 1)
						parBit = Rxd;
					else
						stopSh[bitIdx - `DATA_BITS - 2] = Rxd;
					if (bitIdx == FrameLen - 1)
					begin
						// A looped back frame carries the written byte, even parity and high stops
						if (txQ.size() != 0)
						begin
							txByte = txQ.pop_front();
							expFrame = {txByte, ^txByte, {`STOP_BITS{1'b1}}};
							if ({dataSh, parBit, stopSh} !== expFrame)
								mismatch("Txd frame", 32'(expFrame),
									32'({dataSh, parBit, stopSh}));
						end
						res = predictFrame(dataSh, parBit, stopSh);
						if (res[`DATA_BITS+3])
						begin
							if (rxFull)
								ovr = 1'b1;
							else
							begin
								rxHold = res[`DATA_BITS-1:0];
								rxFull = 1'b1;
							end
						end
						brkF = brkF || res[`DATA_BITS+2];
						parF = parF || res[`DATA_BITS+1];
						frmF = frmF || res[`DATA_BITS];
						rxActive = 1'b0;
					end
					bitIdx++;
				end
			end
			lastRxd = Rxd;

			if (TestDone)
			begin
				if (Rts !== 1'b1)
					failNote("Rts is low although the receive line is idle");
				if (bQ.size() != 0 || rQ.size() != 0)
					failNote("a bus response never arrived");
				if (txQ.size() != 0)
					failNote("a byte written to TXDATA never appeared on the line");
				$display("Test %0s finished with %0d errors", TestName, testErrs);
				testsRun++;
				if (testErrs != 0)
					testsFailed++;
				testErrs = 0;
			end
			if (Finish)
				$display("Tests run %0d, tests failed %0d, failed checks %0d",
					testsRun, testsFailed, ErrCount);
		end
	end

endmodule

//--- bench/uartTb.sv
// Runs the serial side at TestDiv; frames are injected or looped back one at a time
`include "uart_macros.svh"

module uartTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TestDiv = 3;
	localparam int LoopBytes = 4;
	localparam int BitClocks = `OVERSAMPLE * (TestDiv + 1);
	localparam int FrameClocks = 12 * BitClocks;
	localparam int FrameCount = 12;
	localparam int HandshakeLimit = 100;
	// Frames times 12 bits times OVERSAMPLE times (divisor+1) times 4 ns, doubled, plus margin
	localparam int WatchdogNs = FrameCount * FrameClocks * 4 * 2 + 20000;

	logic Clk;
	logic Rst;
	logic [`ADDR_WIDTH-1:0] AwAddr;
	logic AwValid;
	logic AwReady;
	logic [31:0] WData;
	logic [3:0] WStrb;
	logic WValid;
	logic WReady;
	logic [1:0] BResp;
	logic BValid;
	logic BReady;
	logic [`ADDR_WIDTH-1:0] ArAddr;
	logic ArValid;
	logic ArReady;
	logic [31:0] RData;
	logic [1:0] RResp;
	logic RValid;
	logic RReady;
	logic Rxd;
	logic Txd;
	logic Rts;
	logic loopSel;
	logic injLine;
	logic [31:0] lfsr;
	logic [8*20-1:0] testName;
	logic testDone;
	logic finish;
	int errCount;
	int tbErrors;
	logic [7:0] b;

	uartTop u_uartTop (
		.Clk(Clk), .Rst(Rst),
		.AwAddr(AwAddr), .AwValid(AwValid), .AwReady(AwReady),
		.WData(WData), .WStrb(WStrb), .WValid(WValid), .WReady(WReady),
		.BResp(BResp), .BValid(BValid), .BReady(BReady),
		.ArAddr(ArAddr), .ArValid(ArValid), .ArReady(ArReady),
		.RData(RData), .RResp(RResp), .RValid(RValid), .RReady(RReady),
		.Rxd(Rxd), .Txd(Txd), .Rts(Rts)
	);

	uartChecker u_checker (
		.Clk(Clk), .Rst(Rst),
		.AwAddr(AwAddr), .AwValid(AwValid), .AwReady(AwReady), .WData(WData),
		.WReady(WReady),
		.BResp(BResp), .BValid(BValid), .BReady(BReady),
		.ArAddr(ArAddr), .ArValid(ArValid), .ArReady(ArReady),
		.RData(RData), .RResp(RResp), .RValid(RValid), .RReady(RReady),
		.Rxd(Rxd), .Txd(Txd), .Rts(Rts),
		.TestName(testName), .TestDone(testDone), .Finish(finish), .ErrCount(errCount)
	);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	// Receive line comes from the transmitter or from the frame injector
	always @(posedge Clk)
		Rxd <= loopSel ? Txd : injLine;

	initial
	begin
		#(WatchdogNs);
		$display("Watchdog expired before the test sequence ended");
		$display("Something failed");
		$finish;
	end

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic randomByte(output logic [7:0] v);
		v = '0;
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsrNext(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic axiWrite(input logic [`ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		int waitCnt;
		waitCnt = 0;
		AwAddr <= addr;
		AwValid <= 1'b1;
		WData <= data;
		WValid <= 1'b1;
		do
		begin
			@(posedge Clk);
			waitCnt++;
		end
		while (!AwReady && waitCnt < HandshakeLimit);
		AwValid <= 1'b0;
		WValid <= 1'b0;
		if (!AwReady)
		begin
			$display("Write address and data were never accepted");
			tbErrors++;
		end
		waitCnt = 0;
		do
		begin
			@(posedge Clk);
			waitCnt++;
		end
		while (!BValid && waitCnt < HandshakeLimit);
	endtask

	task automatic axiRead(input logic [`ADDR_WIDTH-1:0] addr);
		int waitCnt;
		waitCnt = 0;
		ArAddr <= addr;
		ArValid <= 1'b1;
		do
		begin
			@(posedge Clk);
			waitCnt++;
		end
		while (!ArReady && waitCnt < HandshakeLimit);
		ArValid <= 1'b0;
		if (!ArReady)
		begin
			$display("Read address was never accepted");
			tbErrors++;
		end
		waitCnt = 0;
		do
		begin
			@(posedge Clk);
			waitCnt++;
		end
		while (!RValid && waitCnt < HandshakeLimit);
	endtask

	// Start bit, data MSB first, parity, then stops[0] and stops[1]
	task automatic sendFrame(input logic [7:0] data, input logic parity, input logic [1:0] stops);
		logic [11:0] bits;
		bits = {1'b0, data, parity, stops[0], stops[1]};
		for (int i = 11; i >= 0; i--)
		begin
			injLine <= bits[i];
			repeat (BitClocks) @(posedge Clk);
		end
		injLine <= 1'b1;
		repeat (2 * BitClocks) @(posedge Clk);
	endtask

	// Rts drops while the receiver is busy and rises when the frame is done
	task automatic waitFrame();
		int waitCnt;
		waitCnt = 0;
		while (Rts && waitCnt < 2 * FrameClocks)
		begin
			@(posedge Clk);
			waitCnt++;
		end
		while (!Rts && waitCnt < 4 * FrameClocks)
		begin
			@(posedge Clk);
			waitCnt++;
		end
		if (waitCnt >= 4 * FrameClocks || (waitCnt >= 2 * FrameClocks && Rts))
		begin
			$display("Receiver never finished a looped back frame");
			tbErrors++;
		end
		repeat (2 * BitClocks) @(posedge Clk);
	endtask

	task automatic startTest(input logic [8*20-1:0] name);
		testName <= name;
		@(posedge Clk);
	endtask

	task automatic endTest();
		testDone <= 1'b1;
		@(posedge Clk);
		testDone <= 1'b0;
		@(posedge Clk);
	endtask

	initial
	begin
		Rst = 1'b1;
		AwAddr = '0;
		AwValid = 1'b0;
		WData = '0;
		WStrb = 4'hF;
		WValid = 1'b0;
		BReady = 1'b1;
		ArAddr = '0;
		ArValid = 1'b0;
		RReady = 1'b1;
		Rxd = 1'b1;
		loopSel = 1'b0;
		injLine = 1'b1;
		lfsr = 32'ha92b;
		testName = "reset";
		testDone = 1'b0;
		finish = 1'b0;
		tbErrors = 0;
		repeat (4) @(posedge Clk);
		Rst <= 1'b0;
		@(posedge Clk);

		startTest("reset values");
		axiRead(uartPkg::RegStatus);
		axiRead(uartPkg::RegDivisor);
		endTest();

		startTest("loopback");
		loopSel <= 1'b1;
		axiWrite(uartPkg::RegDivisor, TestDiv);
		for (int n = 0; n < LoopBytes; n++)
		begin
			randomByte(b);
			axiWrite(uartPkg::RegTxData, {24'h0, b});
			waitFrame();
			axiRead(uartPkg::RegStatus);
			axiRead(uartPkg::RegRxData);
			axiRead(uartPkg::RegStatus);
		end
		endTest();

		startTest("tx busy");
		randomByte(b);
		axiWrite(uartPkg::RegTxData, {24'h0, b});
		randomByte(b);
		axiWrite(uartPkg::RegTxData, {24'h0, b});
		axiRead(uartPkg::RegStatus);
		waitFrame();
		axiRead(uartPkg::RegRxData);
		// A second frame would show up as rxValid here
		repeat (FrameClocks) @(posedge Clk);
		axiRead(uartPkg::RegStatus);
		endTest();

		startTest("rx errors");
		loopSel <= 1'b0;
		randomByte(b);
		sendFrame(b, !(^b), 2'b11);
		axiRead(uartPkg::RegStatus);
		axiWrite(uartPkg::RegStatus, 32'h1 << `ST_PARITY);
		axiRead(uartPkg::RegStatus);
		randomByte(b);
		sendFrame(b, ^b, 2'b10);
		axiRead(uartPkg::RegStatus);
		axiWrite(uartPkg::RegStatus, 32'h1 << `ST_FRAMING);
		axiRead(uartPkg::RegStatus);
		sendFrame(8'h00, 1'b0, 2'b10);
		axiRead(uartPkg::RegStatus);
		axiWrite(uartPkg::RegStatus, 32'h3F);
		axiRead(uartPkg::RegStatus);
		endTest();

		startTest("overrun");
		randomByte(b);
		sendFrame(b, ^b, 2'b11);
		randomByte(b);
		sendFrame(b, ^b, 2'b11);
		axiRead(uartPkg::RegStatus);
		axiRead(uartPkg::RegRxData);
		axiRead(uartPkg::RegStatus);
		axiWrite(uartPkg::RegStatus, 32'h1 << `ST_OVERRUN);
		axiRead(uartPkg::RegStatus);
		endTest();

		startTest("unmapped address");
		axiWrite(4'h2, 32'h0000_FFFF);
		axiRead(4'h6);
		axiRead(uartPkg::RegDivisor);
		axiRead(uartPkg::RegStatus);
		endTest();

		finish <= 1'b1;
		@(posedge Clk);
		finish <= 1'b0;
		repeat (2) @(posedge Clk);
		if (errCount == 0 && tbErrors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+src
src/uartPkg.sv
src/baudTickGen.sv
src/uartRx.sv
src/uartTx.sv
src/uartAxiRegs.sv
src/uartTop.sv
bench/uartChecker.sv
bench/uartTb.sv

//--- run.sh
#!/bin/sh
# Builds the UART bench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module uartTb -f files.f -o simv

# The simulator status is not trusted alone, the log decides
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
